// ==== kbd_seg_top.f ====
+incdir+dv
verilog/kbd_pkg.sv
verilog/ps2_rx.sv
verilog/scan_fifo.sv
verilog/seg_serial.sv
verilog/kbd_seg_top.sv
dv/tb_kbd_seg.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the kbd_seg_top testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_kbd_seg -f kbd_seg_top.f \
    || { echo "verilator build failed"; exit 1; }

./obj_dir/Vtb_kbd_seg > sim.log 2>&1 || true
cat sim.log

# the log decides the result
grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "no pass message in sim.log"; exit 1; }
echo "simulation passed"
exit 0

// ==== dv/tb_kbd_seg_util.svh ====
// helpers included inside tb_kbd_seg; they use its clk200m, PS/2 lines and segment outputs
`ifndef TB_KBD_SEG_UTIL_SVH
`define TB_KBD_SEG_UTIL_SVH

    // keyboard clock half period in clk200m cycles
    localparam int PS2_HALF = 10;

    // standard a..g patterns indexed by hex digit, dp off
    logic [7:0] seg_table [16] = '{
        8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
        8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71
    };

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk200m);
    endtask

    // start, 8 data lsb first, odd parity, stop
    task automatic send_ps2(input logic [7:0] code, input bit bad_parity);
        logic [10:0] frame;
        logic        parity;
        parity = ~^code;
        if (bad_parity) begin
            parity = ~parity;
        end
        frame = {1'b1, parity, code, 1'b0};
        for (int i = 0; i < 11; i++) begin
            // data changes while the keyboard clock is high
            @(posedge clk200m);
            ps2_data <= frame[i];
            wait_cycles(PS2_HALF / 2);
            ps2_clk <= 1'b0;
            wait_cycles(PS2_HALF);
            ps2_clk <= 1'b1;
            wait_cycles(PS2_HALF - PS2_HALF / 2 - 1);
        end
    endtask

    // pattern back to a digit, 0 when no table entry matches
    function automatic bit decode_digit(input logic [7:0] pat, output logic [3:0] digit);
        decode_digit = 1'b0;
        digit = '0;
        for (int d = 0; d < 16; d++) begin
            if (seg_table[d] == pat) begin
                digit = d[3:0];
                decode_digit = 1'b1;
            end
        end
    endfunction

    // set seen if seg_en drops at any edge in the window
    task automatic watch_quiet(input int cycles, output bit seen);
        seen = 1'b0;
        repeat (cycles) begin
            @(posedge clk200m);
            if (seg_en !== 1'b1) begin
                seen = 1'b1;
            end
        end
    endtask

    // one display frame between seg_en falling and rising
    task automatic capture_frame(input int max_wait, output bit got, output bit valid,
                                 output logic [31:0] num);
        logic [63:0] bits;
        logic [3:0]  digit;
        logic        clk_prev;
        int          nbits;
        int          waited;
        got = 1'b0;
        valid = 1'b0;
        num = '0;
        bits = '0;
        nbits = 0;
        waited = 0;
        clk_prev = 1'b0;
        while (seg_en === 1'b1 && waited < max_wait) begin
            @(posedge clk200m);
            waited++;
        end
        if (seg_en === 1'b0) begin
            got = 1'b1;
            waited = 0;
            // values seen here are the ones before the edge
            while (seg_en === 1'b0 && waited < SEG_BITS * SEG_BIT_CYCLES + 8) begin
                @(posedge clk200m);
                waited++;
                if (seg_clk === 1'b1 && clk_prev === 1'b0) begin
                    bits = {bits[62:0], seg_dout};
                    nbits++;
                end
                clk_prev = seg_clk;
            end
            valid = (nbits == SEG_BITS) && (seg_en === 1'b1);
            // digit 7 went out first so it sits on top
            for (int d = 0; d < 8; d++) begin
                if (!decode_digit(bits[d*8 +: 8], digit)) begin
                    valid = 1'b0;
                end
                num[d*4 +: 4] = digit;
            end
        end
    endtask

`endif

// ==== dv/tb_kbd_seg.sv ====
// directed testbench for kbd_seg_top; ideal PS/2 timing and no host-to-device traffic
`timescale 1ns/1ps

module tb_kbd_seg;
    import kbd_pkg::*;

    localparam int CLK_PERIOD = 20;

    logic       clk200m;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_data;
    logic       hold;
    logic [7:0] leds;
    logic       seg_clk;
    logic       seg_clrn;
    logic       seg_dout;
    logic       seg_en;

    // reference model of the queued codes and the shown number
    scan_code_t expect_q[$];
    disp_num_t  model_num;
    bit         model_overflow;
    // number decoded from the most recent display frame
    logic [31:0] shown_num;

    `include "tb_kbd_seg_util.svh"

    // one keyboard frame then one display frame
    localparam int PS2_FRAME_CYCLES = 11 * 2 * PS2_HALF;
    localparam int DISP_FRAME_CYCLES = SEG_BITS * SEG_BIT_CYCLES + 8;
    localparam int FRAME_CYCLES = PS2_FRAME_CYCLES + DISP_FRAME_CYCLES;
    // 1 + 5 + 3 + 10 + 8 + 1 frame slots plus the reset window
    localparam int TOTAL_FRAMES = 29;
    localparam int WATCHDOG_NS = 2 * TOTAL_FRAMES * FRAME_CYCLES * CLK_PERIOD;

    kbd_seg_top dut0 (
        .clk200m  (clk200m),
        .rst      (rst),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .hold     (hold),
        .leds     (leds),
        .seg_clk  (seg_clk),
        .seg_clrn (seg_clrn),
        .seg_dout (seg_dout),
        .seg_en   (seg_en)
    );

    initial begin
        clk200m = 1'b0;
        forever #(CLK_PERIOD / 2) clk200m = ~clk200m;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns with tests still running", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

    task automatic expect_equal(input string test, input logic [31:0] expected,
                                input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("Mismatch in %s: expected %h, actual %h", test, expected, actual);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    task automatic expect_true(input string test, input bit cond, input string what);
        assert (cond) else begin
            $display("Error in %s: %s", test, what);
            $display("SOME TESTS FAILED");
            $fatal(1, "stopping at the first error");
        end
    endtask

    // producer side of the model, credits equal the FIFO depth
    task automatic model_send(input scan_code_t code);
        if (expect_q.size() < FIFO_DEPTH) begin
            expect_q.push_back(code);
        end else begin
            model_overflow = 1'b1;
        end
    endtask

    // next frame must show the model number with the oldest pending code appended
    task automatic check_display(input string test, input int max_wait);
        bit          got;
        bit          valid;
        logic [31:0] num;
        scan_code_t  code;
        capture_frame(max_wait, got, valid, num);
        shown_num = num;
        expect_true(test, got, "no display frame arrived in time");
        expect_true(test, valid, "display frame had a bad length or unknown segment pattern");
        expect_true(test, expect_q.size() > 0, "display frame arrived with no key pending");
        code = expect_q.pop_front();
        model_num = {model_num[23:0], code};
        expect_equal(test, model_num, num);
    endtask

    task automatic send_and_check(input string test, input scan_code_t code);
        model_send(code);
        fork
            send_ps2(code, 1'b0);
            check_display(test, FRAME_CYCLES);
        join
    endtask

    task automatic test_reset_state;
        bit seen;
        expect_equal("reset_state", 32'd1, {31'd0, seg_en});
        expect_equal("reset_state", 32'd1, {31'd0, seg_clrn});
        expect_equal("reset_state", 32'd0, {31'd0, seg_clk});
        expect_equal("reset_state", 32'd0, {24'd0, leds});
        watch_quiet(100, seen);
        expect_true("reset_state", !seen, "display frame started with no key sent");
    endtask

    task automatic test_single_key;
        scan_code_t code;
        code = scan_code_t'($urandom());
        send_and_check("single_key", code);
        // first key on a cleared display, upper six digits read back as zero
        expect_equal("single_key", {24'd0, code}, shown_num);
        expect_equal("single_key", {24'd0, 1'b0, code[6:0]}, {24'd0, leds});
    endtask

    task automatic test_rolling;
        for (int i = 0; i < 5; i++) begin
            send_and_check("rolling", scan_code_t'($urandom()));
        end
    endtask

    task automatic test_framing;
        bit seen;
        fork
            send_ps2(scan_code_t'($urandom()), 1'b1);
            watch_quiet(FRAME_CYCLES, seen);
        join
        expect_true("framing", !seen, "frame with bad parity reached the display");
        send_and_check("framing", scan_code_t'($urandom()));
    endtask

    task automatic test_backpressure;
        bit         seen;
        scan_code_t last;
        @(posedge clk200m);
        hold <= 1'b1;
        for (int i = 0; i < 10; i++) begin
            last = scan_code_t'($urandom());
            model_send(last);
            send_ps2(last, 1'b0);
        end
        wait_cycles(PS2_HALF);
        expect_equal("backpressure", {31'd0, model_overflow}, {31'd0, leds[7]});
        last = expect_q[FIFO_DEPTH - 1];
        @(posedge clk200m);
        hold <= 1'b0;
        // the FIFO drains oldest first
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            check_display("backpressure", 2 * DISP_FRAME_CYCLES);
        end
        watch_quiet(FRAME_CYCLES, seen);
        expect_true("backpressure", !seen, "a ninth display frame followed the drain");
        expect_equal("backpressure", {24'd0, 1'b1, last[6:0]}, {24'd0, leds});
    endtask

    initial begin
        void'($urandom(32'h3d1e));
        rst = 1'b1;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        hold = 1'b0;
        model_num = '0;
        model_overflow = 1'b0;
        shown_num = '0;
        repeat (2) @(posedge clk200m);
        rst <= 1'b0;
        @(posedge clk200m);
        test_reset_state();
        test_single_key();
        test_rolling();
        test_framing();
        test_backpressure();
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

// ==== verilog/kbd_seg_top.sv ====
// keyboard-to-display slice; clk200m arrives single-ended, no clock buffering or division here
`timescale 1ns/1ps

module kbd_seg_top (
    input  logic       clk200m,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_data,
    input  logic       hold,
    output logic [7:0] leds,
    output logic       seg_clk,
    output logic       seg_clrn,
    output logic       seg_dout,
    output logic       seg_en
);
    import kbd_pkg::*;

    // producer to FIFO
    logic       push;
    scan_code_t push_code;
    logic       credit_ret;
    logic       overflow;

    // FIFO to display driver
    scan_code_t kb_code;
    logic       kb_ready;
    logic       pop;
    scan_code_t last_code;

    // overflow on top, low bits of the shown code below
    assign leds = {overflow, last_code[6:0]};

    ps2_rx u_ps2_rx (
        .clk200m    (clk200m),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .credit_ret (credit_ret),
        .push       (push),
        .push_code  (push_code),
        .overflow   (overflow)
    );

    scan_fifo u_scan_fifo (
        .clk200m    (clk200m),
        .rst        (rst),
        .push       (push),
        .push_code  (push_code),
        .pop        (pop),
        .kb_code    (kb_code),
        .kb_ready   (kb_ready),
        .credit_ret (credit_ret)
    );

    seg_serial u_seg_serial (
        .clk200m   (clk200m),
        .rst       (rst),
        .kb_code   (kb_code),
        .kb_ready  (kb_ready),
        .hold      (hold),
        .pop       (pop),
        .last_code (last_code),
        .seg_clk   (seg_clk),
        .seg_clrn  (seg_clrn),
        .seg_dout  (seg_dout),
        .seg_en    (seg_en)
    );

endmodule

// ==== verilog/seg_serial.sv ====
// serial 8-digit segment driver; expects an external shift register latched by seg_en rising
`timescale 1ns/1ps

module seg_serial (
    input  logic                clk200m,
    input  logic                rst,
    input  kbd_pkg::scan_code_t kb_code,
    input  logic                kb_ready,
    input  logic                hold,
    output logic                pop,
    output kbd_pkg::scan_code_t last_code,
    output logic                seg_clk,
    output logic                seg_clrn,
    output logic                seg_dout,
    output logic                seg_en
);
    import kbd_pkg::*;

    typedef enum logic [1:0] {
        ser_idle,
        ser_clear,
        ser_shift,
        ser_latch
    } ser_state_t;

    ser_state_t            state;
    disp_num_t             disp_num;
    logic [SEG_BITS-1:0]   image;
    logic [SEG_BITS-1:0]   shreg;
    logic [SEG_CNT_W-1:0]  phase;
    logic [SEG_IDX_W-1:0]  bit_idx;

    // take a code whenever idle and not paused
    assign pop = (state == ser_idle) && !hold && kb_ready;

    // msb of the shift register goes out first
    assign seg_dout = shreg[SEG_BITS-1];

    // digit 7 in the top byte of the image
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            image[i*8 +: 8] = hex_to_seg(disp_num[i*4 +: 4]);
        end
    end

    // display number and the code shown on the leds
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            disp_num <= '0;
            last_code <= '0;
        end else if (pop) begin
            // older codes move up one byte
            disp_num <= {disp_num[23:0], kb_code};
            last_code <= kb_code;
        end
    end

    // clear, shift, latch sequence
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state <= ser_idle;
            shreg <= '0;
            phase <= '0;
            bit_idx <= '0;
            seg_clk <= 1'b0;
            seg_clrn <= 1'b1;
            seg_en <= 1'b1;
        end else begin
            case (state)
                ser_idle: begin
                    if (pop) begin
                        state <= ser_clear;
                        seg_clrn <= 1'b0;
                    end
                end
                ser_clear: begin
                    // disp_num already holds the new code here
                    shreg <= image;
                    phase <= '0;
                    bit_idx <= '0;
                    seg_clk <= 1'b0;
                    seg_clrn <= 1'b1;
                    seg_en <= 1'b0;
                    state <= ser_shift;
                end
                ser_shift: begin
                    phase <= phase + 1'b1;
                    // clock high for the second half of the bit
                    if (phase == SEG_CNT_W'(SEG_HALF - 1)) begin
                        seg_clk <= 1'b1;
                    end
                    if (phase == SEG_CNT_W'(SEG_BIT_CYCLES - 1)) begin
                        seg_clk <= 1'b0;
                        phase <= '0;
                        shreg <= {shreg[SEG_BITS-2:0], 1'b0};
                        if (bit_idx == SEG_IDX_W'(SEG_BITS - 1)) begin
                            // all 64 bits out, latch the digits
                            seg_en <= 1'b1;
                            state <= ser_latch;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                        end
                    end
                end
                default: begin
                    state <= ser_idle;
                end
            endcase
        end
    end

endmodule

// ==== verilog/scan_fifo.sv ====
// scan-code FIFO; no full check, the producer's credits keep pushes within FIFO_DEPTH
`timescale 1ns/1ps

module scan_fifo (
    input  logic                clk200m,
    input  logic                rst,
    input  logic                push,
    input  kbd_pkg::scan_code_t push_code,
    input  logic                pop,
    output kbd_pkg::scan_code_t kb_code,
    output logic                kb_ready,
    output logic                credit_ret
);
    import kbd_pkg::*;

    scan_code_t     mem [FIFO_DEPTH];
    fifo_ptr_t      wr_ptr;
    fifo_ptr_t      rd_ptr;
    logic [PTR_W:0] count;
    logic           pop_ok;

    // head of queue straight from the array
    assign kb_code = mem[rd_ptr];
    assign kb_ready = (count != '0);

    // pop on empty is ignored
    assign pop_ok = pop & kb_ready;

    // storage
    always_ff @(posedge clk200m) begin
        if (push) begin
            mem[wr_ptr] <= push_code;
        end
    end

    // pointers wrap naturally at the power-of-two depth
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_ok) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // occupancy
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else begin
            case ({push, pop_ok})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // one credit back per freed slot, a cycle after the pop
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            credit_ret <= 1'b0;
        end else begin
            credit_ret <= pop_ok;
        end
    end

endmodule

// ==== verilog/ps2_rx.sv ====
// PS/2 receiver; needs PS/2 clock half-periods of at least 8 clk200m cycles, no host-to-device
`timescale 1ns/1ps

module ps2_rx (
    input  logic                clk200m,
    input  logic                rst,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    input  logic                credit_ret,
    output logic                push,
    output kbd_pkg::scan_code_t push_code,
    output logic                overflow
);
    import kbd_pkg::*;

    typedef enum logic [1:0] {
        rx_idle,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_t;

    rx_state_t            state;
    logic [1:0]           clk_sync;
    logic [1:0]           data_sync;
    logic                 clk_prev;
    logic                 fall;
    logic                 din;
    logic [2:0]           bit_cnt;
    logic                 par_acc;
    logic                 par_ok;
    logic [TIMEOUT_W-1:0] tmo_cnt;
    logic                 tmo_hit;
    scan_code_t           shreg;
    credit_t              credit;
    logic                 frame_done;
    logic                 take;

    // falling edge on the synchronized keyboard clock
    assign fall = clk_prev & ~clk_sync[1];
    assign din = data_sync[1];
    assign tmo_hit = (state != rx_idle) && (tmo_cnt == TIMEOUT_W'(PS2_TIMEOUT - 1));

    // good stop bit with odd parity seen
    assign frame_done = fall && (state == rx_stop) && din && par_ok;
    // only push when the FIFO has granted space
    assign take = frame_done && (credit != '0);

    // two-flop synchronizers, lines idle high
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            clk_sync <= 2'b11;
            data_sync <= 2'b11;
            clk_prev <= 1'b1;
        end else begin
            clk_sync <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev <= clk_sync[1];
        end
    end

    // frame FSM
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            state <= rx_idle;
            bit_cnt <= '0;
            par_acc <= 1'b0;
            par_ok <= 1'b0;
            tmo_cnt <= '0;
        end else begin
            // restart the inactivity timer on every edge
            if (fall || state == rx_idle) begin
                tmo_cnt <= '0;
            end else begin
                tmo_cnt <= tmo_cnt + 1'b1;
            end
            if (tmo_hit) begin
                state <= rx_idle;
            end else if (fall) begin
                case (state)
                    rx_idle: begin
                        // start bit must be 0
                        if (!din) begin
                            state <= rx_data;
                            bit_cnt <= '0;
                            par_acc <= 1'b0;
                        end
                    end
                    rx_data: begin
                        par_acc <= par_acc ^ din;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= rx_parity;
                        end
                    end
                    rx_parity: begin
                        // odd parity over data plus parity bit
                        par_ok <= par_acc ^ din;
                        state <= rx_stop;
                    end
                    default: begin
                        state <= rx_idle;
                    end
                endcase
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk200m) begin
        if (fall && state == rx_data) begin
            shreg <= {din, shreg[7:1]};
        end
        if (take) begin
            push_code <= shreg;
        end
    end

    // credits, push strobe and sticky overflow
    always_ff @(posedge clk200m or posedge rst) begin
        if (rst) begin
            credit <= credit_t'(FIFO_DEPTH);
            push <= 1'b0;
            overflow <= 1'b0;
        end else begin
            push <= take;
            case ({take, credit_ret})
                2'b10: credit <= credit - 1'b1;
                2'b01: credit <= credit + 1'b1;
                default: credit <= credit;
            endcase
            // good byte but nowhere to put it
            if (frame_done && credit == '0) begin
                overflow <= 1'b1;
            end
        end
    end

endmodule

// ==== verilog/kbd_pkg.sv ====
// shared widths and helpers; FIFO_DEPTH must stay a power of two for the pointer wrap
package kbd_pkg;

    // buffer depth, also the producer's starting credit
    localparam int FIFO_DEPTH = 8;
    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CREDIT_W = $clog2(FIFO_DEPTH + 1);

    // clk200m cycles per serial segment bit
    localparam int SEG_BIT_CYCLES = 4;
    localparam int SEG_HALF = SEG_BIT_CYCLES / 2;
    localparam int SEG_CNT_W = $clog2(SEG_BIT_CYCLES);
    localparam int SEG_BITS = 64;
    localparam int SEG_IDX_W = $clog2(SEG_BITS);

    // idle cycles before a partial PS/2 frame is dropped
    localparam int PS2_TIMEOUT = 2000;
    localparam int TIMEOUT_W = $clog2(PS2_TIMEOUT);

    typedef logic [7:0] scan_code_t;
    typedef logic [31:0] disp_num_t;
    // dp,g,f,e,d,c,b,a with dp held at 0
    typedef logic [7:0] seg_pat_t;
    typedef logic [CREDIT_W-1:0] credit_t;
    typedef logic [PTR_W-1:0] fifo_ptr_t;

    // hex digit to active-high segment pattern
    function automatic seg_pat_t hex_to_seg(input logic [3:0] digit);
        case (digit)
            4'h0: hex_to_seg = 8'h3f;
            4'h1: hex_to_seg = 8'h06;
            4'h2: hex_to_seg = 8'h5b;
            4'h3: hex_to_seg = 8'h4f;
            4'h4: hex_to_seg = 8'h66;
            4'h5: hex_to_seg = 8'h6d;
            4'h6: hex_to_seg = 8'h7d;
            4'h7: hex_to_seg = 8'h07;
            4'h8: hex_to_seg = 8'h7f;
            4'h9: hex_to_seg = 8'h6f;
            4'ha: hex_to_seg = 8'h77;
            4'hb: hex_to_seg = 8'h7c;
            4'hc: hex_to_seg = 8'h39;
            4'hd: hex_to_seg = 8'h5e;
            4'he: hex_to_seg = 8'h79;
            default: hex_to_seg = 8'h71;
        endcase
    endfunction

endpackage
